// File: Bender.yml
package:
  name: breakout_video

export_include_dirs:
  - src

sources:
  - src/video_pkg.sv
  - src/game_pkg.sv
  - src/raster_scan.sv
  - src/frame_state.sv
  - src/score_digits.sv
  - src/playfield_shader.sv
  - src/breakout_video.sv
  - target: simulation
    files:
      - sim/video_checker.sv
      - sim/tb_breakout_video.sv

// File: breakout_video.f
+incdir+src
src/video_pkg.sv
src/game_pkg.sv
src/raster_scan.sv
src/frame_state.sv
src/score_digits.sv
src/playfield_shader.sv
src/breakout_video.sv
sim/video_checker.sv
sim/tb_breakout_video.sv

// File: sim/breakout_testdata.txt
# S frame paddle_x ball_x ball_y bricks_alive_hex score
# E frame game_x game_y expected_color_hex
S 0 160 138 212 ffffffffffff 507
S 1 160 138 212 fffffffffffe 507
S 2 160 156 205 fffffffffffe 507
E 0 100 0 010a
E 0 100 239 04b8
E 0 200 100 0290
E 1 5 32 07e0
E 1 281 105 07e0
E 1 38 35 018c
E 1 20 42 01ac
E 1 145 215 f800
E 1 139 219 f800
E 1 150 218 ffe0
E 1 176 215 0457
E 1 284 4 ffff
E 1 286 6 010a
E 1 296 10 ffff
E 1 298 10 012a
E 1 308 17 014b
E 1 315 17 ffff
E 1 293 4 010a
E 1 306 10 012a
E 2 20 35 ffff
E 2 170 215 ffe0
E 3 170 215 ffff
E 3 160 211 f800
E 7 20 35 ffff
E 8 20 35 018c
E 10 170 215 ffff
E 11 170 215 ffe0

// File: sim/tb_breakout_video.sv
/*
 * Breakout video testbench
 * Plays per-frame game states from the test data file into the DUT
 * under random back-pressure. The checker compares listed pixels.
 */
`default_nettype none
`include "breakout_settings.svh"

module tb_breakout_video;
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;
    import game_pkg::*;

    localparam int MAX_FRAMES   = 32;
    localparam int FRAME_PIXELS = `LCD_W * `LCD_H;

    logic        clk = 1'b0;
    logic        reset_n;
    coord_t      paddle_x;
    coord_t      ball_x;
    coord_t      ball_y;
    brick_mask_t bricks_alive;
    score_t      score;
    logic        pixel_ready;
    logic        pixel_valid;
    rgb565_t     pixel_color;
    int          frames_total = 0;
    int          frame_no;
    int          errors;
    int          checks;
    logic        done;
    int          seed = 32'ha2a6_b265;
    bit          file_ok;

    // Game state per frame, applied while that frame streams out
    coord_t      st_paddle [MAX_FRAMES];
    coord_t      st_ball_x [MAX_FRAMES];
    coord_t      st_ball_y [MAX_FRAMES];
    brick_mask_t st_bricks [MAX_FRAMES];
    score_t      st_score  [MAX_FRAMES];
    bit          st_given  [MAX_FRAMES];

    always #20 clk = ~clk;

    breakout_video i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .paddle_x     (paddle_x),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .bricks_alive (bricks_alive),
        .score        (score),
        .pixel_ready  (pixel_ready),
        .pixel_valid  (pixel_valid),
        .pixel_color  (pixel_color)
    );

    video_checker i_checker (
        .clk          (clk),
        .reset_n      (reset_n),
        .pixel_valid  (pixel_valid),
        .pixel_ready  (pixel_ready),
        .pixel_color  (pixel_color),
        .frames_total (frames_total),
        .frame_no     (frame_no),
        .done         (done),
        .errors       (errors),
        .checks       (checks)
    );

    // ----------------------------------------
    task automatic load_testdata();
        int               fd;
        int               code;
        int               f;
        int               gx;
        int               gy;
        int               px;
        int               bx;
        int               by;
        int               sc;
        logic [47:0]      bm;
        logic [15:0]      col;
        logic [8*160-1:0] line;
        logic [8*8-1:0]   tag;
        fd      = $fopen("sim/breakout_testdata.txt", "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while (!$feof(fd)) begin
                tag  = '0;
                code = $fgets(line, fd);
                if (code > 0)
                    code = $sscanf(line, "%s", tag);
                if (tag == "S") begin
                    code = $sscanf(line, "%s %d %d %d %d %h %d", tag, f, px, bx, by, bm, sc);
                    if (code == 7 && f >= 0 && f < MAX_FRAMES) begin
                        st_paddle[f] = coord_t'(px);
                        st_ball_x[f] = coord_t'(bx);
                        st_ball_y[f] = coord_t'(by);
                        st_bricks[f] = bm;
                        st_score[f]  = score_t'(sc);
                        st_given[f]  = 1'b1;
                    end else begin
                        $display("a state line of the test data could not be read");
                        file_ok = 1'b0;
                    end
                end else if (tag == "E") begin
                    code = $sscanf(line, "%s %d %d %d %h", tag, f, gx, gy, col);
                    if (code == 5 && f >= 0 && f < MAX_FRAMES) begin
                        i_checker.add_expect(f, gx, gy, col);
                        if (f + 1 > frames_total)
                            frames_total = f + 1;
                    end else begin
                        $display("an expected pixel line of the test data could not be read");
                        file_ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Frames without an S line keep the previous state
    task automatic fill_states();
        if (!st_given[0]) begin
            st_paddle[0] = '0;
            st_ball_x[0] = '0;
            st_ball_y[0] = '0;
            st_bricks[0] = '0;
            st_score[0]  = '0;
        end
        for (int k = 1; k < MAX_FRAMES; k++) begin
            if (!st_given[k]) begin
                st_paddle[k] = st_paddle[k-1];
                st_ball_x[k] = st_ball_x[k-1];
                st_ball_y[k] = st_ball_y[k-1];
                st_bricks[k] = st_bricks[k-1];
                st_score[k]  = st_score[k-1];
            end
        end
    endtask

    always @(negedge clk) begin : drive_inputs
        int k;
        if (reset_n) begin
            k = (frame_no < MAX_FRAMES) ? frame_no : MAX_FRAMES - 1;
            paddle_x     <= st_paddle[k];
            ball_x       <= st_ball_x[k];
            ball_y       <= st_ball_y[k];
            bricks_alive <= st_bricks[k];
            score        <= st_score[k];
            pixel_ready  <= (($random(seed) & 3) != 0);    // Low one clock in four
        end
    end

    // ----------------------------------------
    initial begin
        reset_n      = 1'b0;
        paddle_x     = '0;
        ball_x       = '0;
        ball_y       = '0;
        bricks_alive = '0;
        score        = '0;
        pixel_ready  = 1'b0;
        load_testdata();
        fill_states();
        if (!file_ok || frames_total == 0) begin
            $display("the test data file is missing or unusable, nothing was run");
            $display("Errors found");
            $finish;
        end else begin
            repeat (2) @(negedge clk);
            reset_n <= 1'b1;
            wait (done);
            @(negedge clk);
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0)
                $display("No errors");
            else
                $display("Errors found");
            $finish;
        end
    end

    // Four times the length of an unstalled run
    initial begin : watchdog
        wait (frames_total > 0 && reset_n);
        repeat (4 * frames_total * FRAME_PIXELS) @(posedge clk);
        $display("timeout, the pixel stream stopped before all frames were delivered");
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/video_checker.sv
/*
 * Video checker
 * Follows the pixel stream by its handshakes, keeps the physical
 * position and frame, and compares the pixels listed in the test data.
 */
`default_nettype none
`include "breakout_settings.svh"

module video_checker (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               pixel_valid,
    input  logic               pixel_ready,
    input  video_pkg::rgb565_t pixel_color,
    input  int                 frames_total,
    output int                 frame_no,
    output logic               done,
    output int                 errors,
    output int                 checks
);
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;

    localparam int MAX_EXP = 64;

    int      exp_frame [MAX_EXP];
    int      exp_x     [MAX_EXP];
    int      exp_y     [MAX_EXP];
    rgb565_t exp_color [MAX_EXP];
    bit      exp_seen  [MAX_EXP];
    int      n_exp     = 0;
    int      n_err     = 0;
    int      n_chk     = 0;
    int      frame_cnt = 0;
    logic    all_done  = 1'b0;
    int      phys_x    = 0;        // Column of the next transfer
    int      phys_y    = 0;
    int      start_cyc = 0;        // Clocks since reset release, up to 2

    assign frame_no = frame_cnt;
    assign done     = all_done;
    assign errors   = n_err;
    assign checks   = n_chk;

    task automatic add_expect(input int f, input int gx, input int gy, input rgb565_t col);
        if (n_exp < MAX_EXP) begin
            exp_frame[n_exp] = f;
            exp_x[n_exp]     = gx;
            exp_y[n_exp]     = gy;
            exp_color[n_exp] = col;
            n_exp++;
        end else begin
            $display("too many expected pixels in the test data, one was dropped");
            n_err++;
        end
    endtask

    // Compare every listed pixel at this game position
    task automatic check_pixel(input int gx, input int gy);
        for (int i = 0; i < n_exp; i++) begin
            if (exp_frame[i] == frame_cnt && exp_x[i] == gx && exp_y[i] == gy) begin
                exp_seen[i] = 1'b1;
                n_chk++;
                if (pixel_color !== exp_color[i]) begin
                    n_err++;
                    $display("mismatch at %0d ns: frame %0d pixel (%0d,%0d) is %h, expected %h",
                             $time, frame_cnt, gx, gy, pixel_color, exp_color[i]);
                end
            end
        end
    endtask

    task automatic report_missing();
        for (int i = 0; i < n_exp; i++) begin
            if (!exp_seen[i]) begin
                n_err++;
                $display("the pixel of frame %0d at (%0d,%0d) never came out of the stream",
                         exp_frame[i], exp_x[i], exp_y[i]);
            end
        end
    endtask

    // ----------------------------------------
    // Output empty in the first clock, first pixel valid one clock later
    always @(posedge clk) begin
        if (!reset_n) begin
            start_cyc = 0;
        end else if (start_cyc < 2) begin
            start_cyc++;
            n_chk++;
            if (pixel_valid !== (start_cyc == 2)) begin
                n_err++;
                $display("mismatch at %0d ns: pixel_valid is %b in clock %0d after reset",
                         $time, pixel_valid, start_cyc);
            end
        end
    end

    always @(posedge clk) begin
        if (reset_n && !all_done && pixel_valid && pixel_ready) begin
            check_pixel(phys_y, `LCD_W - 1 - phys_x);      // Portrait to game view
            if (phys_x == `LCD_W - 1) begin
                phys_x = 0;
                if (phys_y == `LCD_H - 1) begin
                    phys_y = 0;
                    frame_cnt++;
                    if (frame_cnt >= frames_total) begin
                        report_missing();
                        all_done = 1'b1;
                    end
                end else begin
                    phys_y++;
                end
            end else begin
                phys_x++;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/breakout_settings.svh
/*
 * Breakout video settings
 * Panel and game geometry, playfield layout, score font size,
 * flash lengths and the fixed colors of the playfield.
 */
`ifndef BREAKOUT_SETTINGS_SVH
`define BREAKOUT_SETTINGS_SVH

// ----------------------------------------
// Panel and game area
`define LCD_W               240     // Portrait panel
`define LCD_H               320
`define GAME_W              320     // Landscape game view
`define GAME_H              240

// ----------------------------------------
// Playfield layout
`define BRICK_ROWS          6
`define BRICK_COLS          8
`define BRICK_W             32
`define BRICK_H             9
`define BRICK_X_SP          3
`define BRICK_Y_SP          4
`define BRICK_X0            5
`define BRICK_Y0            32      // Below the score strip
`define PADDLE_W            32
`define PADDLE_H            9
`define PADDLE_Y            210     // Top row of the paddle
`define BALL_SIZE           8

// ----------------------------------------
// Score font, drawn at 2x
`define FONT_W              4
`define FONT_H              7
`define DIGIT_W             8
`define DIGIT_H             14
`define DIGIT_SPACING       4
`define SCORE_X0            284
`define SCORE_Y0            4

// Flash lengths in frames
`define PADDLE_FLASH_FRAMES 8
`define BRICK_FLASH_FRAMES  6

// Colors, RGB565
`define COL_TEXT            16'hFFFF
`define COL_FLASH           16'hFFFF
`define COL_BRICK           16'h07E0
`define COL_PADDLE          16'hFFE0
`define COL_BALL            16'hF800

`endif

// File: src/breakout_video.sv
/*
 * Breakout video top
 * Turns the per-frame game state into an RGB565 pixel stream for a
 * portrait panel, drawn in landscape game coordinates.
 */
`default_nettype none

module breakout_video (
    input  logic                  clk,
    input  logic                  reset_n,
    input  video_pkg::coord_t     paddle_x,      // Paddle center
    input  video_pkg::coord_t     ball_x,        // Ball top-left
    input  video_pkg::coord_t     ball_y,
    input  game_pkg::brick_mask_t bricks_alive,
    input  game_pkg::score_t      score,
    input  logic                  pixel_ready,
    output logic                  pixel_valid,
    output video_pkg::rgb565_t    pixel_color
);
    import video_pkg::*;
    import game_pkg::*;

    logic        coord_valid;
    logic        coord_ready;
    logic        frame_end;
    coord_t      game_x;
    coord_t      game_y;
    coord_t      paddle_left;
    coord_t      ball_left;
    coord_t      ball_top;
    brick_mask_t bricks_shown;
    brick_mask_t brick_flash_mask;
    score_t      score_shown;
    logic        paddle_flash;
    logic        text_hit;

    raster_scan i_scan (
        .clk         (clk),
        .reset_n     (reset_n),
        .coord_ready (coord_ready),
        .coord_valid (coord_valid),
        .frame_end   (frame_end),
        .game_x      (game_x),
        .game_y      (game_y)
    );

    frame_state i_state (
        .clk              (clk),
        .reset_n          (reset_n),
        .frame_end        (frame_end),
        .paddle_x         (paddle_x),
        .ball_x           (ball_x),
        .ball_y           (ball_y),
        .bricks_alive     (bricks_alive),
        .score            (score),
        .paddle_left      (paddle_left),
        .ball_left        (ball_left),
        .ball_top         (ball_top),
        .bricks_shown     (bricks_shown),
        .score_shown      (score_shown),
        .paddle_flash     (paddle_flash),
        .brick_flash_mask (brick_flash_mask)
    );

    score_digits i_score (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_end   (frame_end),
        .score_shown (score_shown),
        .game_x      (game_x),
        .game_y      (game_y),
        .text_hit    (text_hit)
    );

    playfield_shader i_shader (
        .clk              (clk),
        .reset_n          (reset_n),
        .coord_valid      (coord_valid),
        .pixel_ready      (pixel_ready),
        .text_hit         (text_hit),
        .paddle_flash     (paddle_flash),
        .game_x           (game_x),
        .game_y           (game_y),
        .paddle_left      (paddle_left),
        .ball_left        (ball_left),
        .ball_top         (ball_top),
        .bricks_shown     (bricks_shown),
        .brick_flash_mask (brick_flash_mask),
        .coord_ready      (coord_ready),
        .pixel_valid      (pixel_valid),
        .pixel_color      (pixel_color)
    );

endmodule

`default_nettype wire

// File: src/frame_state.sv
/*
 * Frame state
 * Latches the game inputs once per frame so a whole frame is drawn
 * from one state. Runs the paddle-hit and brick-destroy flash
 * counters in frames.
 */
`default_nettype none
`include "breakout_settings.svh"

module frame_state (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  frame_end,
    input  video_pkg::coord_t     paddle_x,
    input  video_pkg::coord_t     ball_x,
    input  video_pkg::coord_t     ball_y,
    input  game_pkg::brick_mask_t bricks_alive,
    input  game_pkg::score_t      score,
    output video_pkg::coord_t     paddle_left,
    output video_pkg::coord_t     ball_left,
    output video_pkg::coord_t     ball_top,
    output game_pkg::brick_mask_t bricks_shown,
    output game_pkg::score_t      score_shown,
    output logic                  paddle_flash,
    output game_pkg::brick_mask_t brick_flash_mask
);
    import video_pkg::*;
    import game_pkg::*;

    logic [9:0]  ball_cx;       // One bit of headroom for the compares
    logic        overlap;
    logic        overlap_d;     // Overlap seen at the previous frame end
    flash_cnt_t  paddle_cnt;
    flash_cnt_t  brick_cnt;
    brick_mask_t gone;
    brick_mask_t gone_mask;

    // Ball center inside the paddle span, ball rows touching paddle rows
    assign ball_cx = {1'b0, ball_x} + 10'(`BALL_SIZE / 2);
    assign overlap = (ball_cx + 10'(`PADDLE_W / 2) >= {1'b0, paddle_x}) &&
                     (ball_cx < {1'b0, paddle_x} + 10'(`PADDLE_W / 2)) &&
                     ({1'b0, ball_y} + 10'(`BALL_SIZE) > 10'(`PADDLE_Y)) &&
                     (ball_y < coord_t'(`PADDLE_Y + `PADDLE_H));

    assign gone = bricks_shown & ~bricks_alive;     // Alive last frame, gone now

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            paddle_left  <= '0;
            ball_left    <= '0;
            ball_top     <= '0;
            bricks_shown <= '0;
            score_shown  <= '0;
            overlap_d    <= 1'b0;
            paddle_cnt   <= '0;
            brick_cnt    <= '0;
            gone_mask    <= '0;
        end else if (frame_end) begin
            paddle_left  <= paddle_x - coord_t'(`PADDLE_W / 2);
            ball_left    <= ball_x;
            ball_top     <= ball_y;
            bricks_shown <= bricks_alive;
            score_shown  <= score;
            overlap_d    <= overlap;
            if (overlap && !overlap_d)
                paddle_cnt <= flash_cnt_t'(`PADDLE_FLASH_FRAMES);
            else if (paddle_cnt != '0)
                paddle_cnt <= paddle_cnt - 1'b1;
            if (gone != '0) begin
                gone_mask <= gone;
                brick_cnt <= flash_cnt_t'(`BRICK_FLASH_FRAMES);
            end else if (brick_cnt != '0) begin
                brick_cnt <= brick_cnt - 1'b1;
            end
        end
    end

    assign paddle_flash     = (paddle_cnt != '0);
    assign brick_flash_mask = (brick_cnt != '0) ? gone_mask : '0;

endmodule

`default_nettype wire

// File: src/game_pkg.sv
/*
 * Game state types
 * Brick masks, score, digit and flash counter types, and the 4x7
 * digit font used by the score display.
 */
`default_nettype none
`include "breakout_settings.svh"

package game_pkg;

    typedef logic [`BRICK_ROWS*`BRICK_COLS-1:0] brick_mask_t;  // Bit row*8 + col
    typedef logic [9:0] score_t;
    typedef logic [3:0] digit_t;
    typedef logic [3:0] flash_cnt_t;    // Counts frames

    // Row-major glyph, MSB is the top-left dot
    function automatic logic [`FONT_W*`FONT_H-1:0] digit_font(input digit_t d);
        case (d)
            4'd0:    return 28'b1111_1001_1001_1001_1001_1001_1111;
            4'd1:    return 28'b0010_0110_0010_0010_0010_0010_0111;
            4'd2:    return 28'b1110_0001_0001_1110_1000_1000_1111;
            4'd3:    return 28'b1110_0001_0001_1110_0001_0001_1110;
            4'd4:    return 28'b1001_1001_1001_1111_0001_0001_0001;
            4'd5:    return 28'b1111_1000_1000_1110_0001_0001_1110;
            4'd6:    return 28'b1111_1000_1000_1111_1001_1001_1111;
            4'd7:    return 28'b1111_0001_0001_0001_0001_0001_0001;
            4'd8:    return 28'b1111_1001_1001_1111_1001_1001_1111;
            4'd9:    return 28'b1111_1001_1001_1111_0001_0001_1111;
            default: return '0;                                 // Not a digit
        endcase
    endfunction

endpackage

`default_nettype wire

// File: src/playfield_shader.sv
/*
 * Playfield shader
 * Colors each game coordinate by layer priority (gradient, score,
 * bricks, paddle, ball) and holds the result in the output pixel
 * register of the valid/ready stream.
 */
`default_nettype none
`include "breakout_settings.svh"

module playfield_shader (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  coord_valid,
    input  logic                  pixel_ready,
    input  logic                  text_hit,
    input  logic                  paddle_flash,
    input  video_pkg::coord_t     game_x,
    input  video_pkg::coord_t     game_y,
    input  video_pkg::coord_t     paddle_left,
    input  video_pkg::coord_t     ball_left,
    input  video_pkg::coord_t     ball_top,
    input  game_pkg::brick_mask_t bricks_shown,
    input  game_pkg::brick_mask_t brick_flash_mask,
    output logic                  coord_ready,
    output logic                  pixel_valid,
    output video_pkg::rgb565_t    pixel_color
);
    import video_pkg::*;

    logic [5:0] grad_g;
    logic [4:0] grad_b;
    rgb565_t    grad_color;
    rgb565_t    color;
    logic       brick_alive_hit;
    logic       brick_flash_hit;
    logic       in_paddle;
    logic       in_ball;
    logic       take;

    // Dark blue toward teal going down the screen
    assign grad_g     = 6'd8 + (game_y[7:2] >> 1);
    assign grad_b     = 5'd10 + (game_y[7:3] >> 1);
    assign grad_color = {5'd0, grad_g, grad_b};

    always_comb begin
        brick_alive_hit = 1'b0;
        brick_flash_hit = 1'b0;
        for (int r = 0; r < `BRICK_ROWS; r++) begin
            for (int c = 0; c < `BRICK_COLS; c++) begin
                if (game_x >= `BRICK_X0 + c * (`BRICK_W + `BRICK_X_SP) &&
                    game_x <  `BRICK_X0 + c * (`BRICK_W + `BRICK_X_SP) + `BRICK_W &&
                    game_y >= `BRICK_Y0 + r * (`BRICK_H + `BRICK_Y_SP) &&
                    game_y <  `BRICK_Y0 + r * (`BRICK_H + `BRICK_Y_SP) + `BRICK_H) begin
                    brick_alive_hit = bricks_shown[r * `BRICK_COLS + c];
                    brick_flash_hit = brick_flash_mask[r * `BRICK_COLS + c];
                end
            end
        end
    end

    assign in_paddle = game_y >= `PADDLE_Y && game_y < `PADDLE_Y + `PADDLE_H &&
                       game_x >= paddle_left && game_x < paddle_left + `PADDLE_W;
    assign in_ball   = game_x >= ball_left && game_x < ball_left + `BALL_SIZE &&
                       game_y >= ball_top && game_y < ball_top + `BALL_SIZE;

    // Later layers win
    always_comb begin
        color = grad_color;
        if (text_hit)
            color = `COL_TEXT;
        if (brick_alive_hit)
            color = `COL_BRICK;
        else if (brick_flash_hit)
            color = `COL_FLASH;              // Ghost of a cleared brick
        if (in_paddle)
            color = paddle_flash ? `COL_FLASH : `COL_PADDLE;
        if (in_ball)
            color = `COL_BALL;
    end

    // ----------------------------------------
    // Output register
    assign coord_ready = !pixel_valid || pixel_ready;
    assign take        = coord_valid && coord_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            pixel_valid <= 1'b0;
        else if (take)
            pixel_valid <= 1'b1;
        else if (pixel_ready)
            pixel_valid <= 1'b0;             // Drained, nothing new
    end

    always_ff @(posedge clk) begin
        if (take)
            pixel_color <= color;
    end

    a_hold_stalled: assert property (@(posedge clk) disable iff (!reset_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_color));

endmodule

`default_nettype wire

// File: src/raster_scan.sv
/*
 * Raster scan
 * Walks the portrait panel x fastest under a valid/ready handshake
 * and offers each position rotated into landscape game coordinates.
 * Marks the transfer of the last pixel of a frame.
 */
`default_nettype none
`include "breakout_settings.svh"

module raster_scan (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              coord_ready,
    output logic              coord_valid,
    output logic              frame_end,
    output video_pkg::coord_t game_x,
    output video_pkg::coord_t game_y
);
    import video_pkg::*;

    coord_t phys_x;     // Column, 0..239
    coord_t phys_y;     // Row, 0..319
    logic   last_x;
    logic   last_y;
    logic   take;

    assign coord_valid = 1'b1;              // The scan never runs dry
    assign take        = coord_valid && coord_ready;
    assign last_x      = (phys_x == coord_t'(`LCD_W - 1));
    assign last_y      = (phys_y == coord_t'(`LCD_H - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phys_x <= '0;
            phys_y <= '0;
        end else if (take) begin
            if (last_x) begin
                phys_x <= '0;
                phys_y <= last_y ? '0 : phys_y + 1'b1;
            end else begin
                phys_x <= phys_x + 1'b1;
            end
        end
    end

    // Portrait to landscape
    assign game_x    = phys_y;
    assign game_y    = coord_t'(`LCD_W - 1) - phys_x;
    assign frame_end = take && last_x && last_y;

    // ----------------------------------------
    a_scan_range: assert property (@(posedge clk) disable iff (!reset_n)
        phys_x < `LCD_W && phys_y < `LCD_H && game_x < `GAME_W && game_y < `GAME_H);

endmodule

`default_nettype wire

// File: src/score_digits.sv
/*
 * Score digits
 * Splits the latched score into three decimal digits and tests each
 * pixel against the three 2x scaled glyph cells of the score.
 */
`default_nettype none
`include "breakout_settings.svh"

module score_digits (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              frame_end,
    input  game_pkg::score_t  score_shown,
    input  video_pkg::coord_t game_x,
    input  video_pkg::coord_t game_y,
    output logic              text_hit
);
    import game_pkg::*;

    score_t score_mod;
    digit_t digits [3];         // Hundreds at index 0, drawn leftmost
    logic   frame_end_d;

    assign score_mod = score_shown % 10'd1000;

    // One clock after frame_end, once score_shown holds the new value.
    // The first pixels of a frame lie far from the score cells.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            frame_end_d <= 1'b0;
            digits      <= '{default: '0};
        end else begin
            frame_end_d <= frame_end;
            if (frame_end_d) begin
                digits[0] <= digit_t'(score_mod / 10'd100);
                digits[1] <= digit_t'((score_mod / 10'd10) % 10'd10);
                digits[2] <= digit_t'(score_mod % 10'd10);
            end
        end
    end

    // ----------------------------------------
    // Glyph hit test
    always_comb begin
        logic [8:0]                  cell_x;
        logic [8:0]                  loc_x;
        logic [8:0]                  loc_y;
        logic [4:0]                  bit_idx;
        logic [`FONT_W*`FONT_H-1:0] glyph;
        text_hit = 1'b0;
        bit_idx  = '0;
        glyph    = '0;
        loc_y    = game_y - 9'(`SCORE_Y0);
        for (int i = 0; i < 3; i++) begin
            cell_x = 9'(`SCORE_X0 + i * (`DIGIT_W + `DIGIT_SPACING));
            loc_x  = game_x - cell_x;
            if (game_x >= cell_x && loc_x < `DIGIT_W &&
                game_y >= `SCORE_Y0 && loc_y < `DIGIT_H) begin
                glyph    = digit_font(digits[i]);
                bit_idx  = 5'(loc_y[8:1] * `FONT_W + loc_x[8:1]);   // Half scale
                text_hit = glyph[`FONT_W*`FONT_H-1 - bit_idx];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/video_pkg.sv
/*
 * Video types
 * Pixel color and screen coordinate types shared by the scan,
 * the frame state and the shader.
 */
`default_nettype none

package video_pkg;

    // One RGB565 pixel, red in the top five bits
    typedef logic [15:0] rgb565_t;

    // Pixel coordinate, wide enough for 0..319 on either axis
    typedef logic [8:0] coord_t;

endpackage

`default_nettype wire
